//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = grayscale_tb
FILELIST  = src.f

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- fifo_if.sv
interface fifo_if #(
    parameter int WIDTH = 8
);

    // push side
    logic             wr_en;
    logic [WIDTH-1:0] din;
    logic             full;

    // pop side, dout is show-ahead
    logic             rd_en;
    logic [WIDTH-1:0] dout;
    logic             empty;

    // producer pushing into the buffer
    modport writer (
        output wr_en,
        output din,
        input  full
    );

    // consumer popping from the buffer
    modport reader (
        output rd_en,
        input  dout,
        input  empty
    );

    // the buffer itself
    modport storage (
        input  wr_en,
        input  din,
        output full,
        input  rd_en,
        output dout,
        output empty
    );

endinterface

//--- grayscale.sv
module grayscale (
    input logic    clock,
    input logic    reset,
    fifo_if.reader pixel_in,
    fifo_if.writer gray_out
);

    import pixel_pkg::*;

    // state encoding
    localparam logic IDLE = 1'b0;
    localparam logic EMIT = 1'b1;

    logic state;
    logic next_state;

    // grey value waiting for room downstream
    logic [GRAY_BITS-1:0] sample;

    // channel fields of the head pixel
    logic [CHANNEL_BITS-1:0] red;
    logic [CHANNEL_BITS-1:0] green;
    logic [CHANNEL_BITS-1:0] blue;

    // red top, green middle, blue low
    assign red   = pixel_in.dout[2*CHANNEL_BITS +: CHANNEL_BITS];
    assign green = pixel_in.dout[CHANNEL_BITS +: CHANNEL_BITS];
    assign blue  = pixel_in.dout[0 +: CHANNEL_BITS];

    // held sample always presented and qualified by wr_en
    assign gray_out.din = sample;

    // state register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // average taken from the show-ahead word on the pop edge
    always_ff @(posedge clock) begin
        if (pixel_in.rd_en) begin
            sample <= rgb_to_gray(red, green, blue);
        end
    end

    // next state and strobes
    always_comb begin
        next_state     = state;
        pixel_in.rd_en = 1'b0;
        gray_out.wr_en = 1'b0;

        case (state)
            IDLE: begin
                // pop one pixel as soon as one is waiting
                if (!pixel_in.empty) begin
                    pixel_in.rd_en = 1'b1;
                    next_state     = EMIT;
                end
            end

            EMIT: begin
                // hold the sample until the sink has space
                if (!gray_out.full) begin
                    gray_out.wr_en = 1'b1;
                    next_state     = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // pop only from a non-empty source with no sample pending
    assert property (@(posedge clock) disable iff (reset)
        pixel_in.rd_en |-> (!pixel_in.empty && state == IDLE))
    else $error("grayscale: pop outside IDLE or from empty source");

    // push only into a sink with room while a sample is held
    assert property (@(posedge clock) disable iff (reset)
        gray_out.wr_en |-> (!gray_out.full && state == EMIT))
    else $error("grayscale: push outside EMIT or into full sink");

endmodule

//--- grayscale_tb.sv
module grayscale_tb;

    import pixel_pkg::*;

    localparam int PERIOD        = 100;
    localparam int IN_DEPTH      = 4;
    localparam int OUT_DEPTH     = 2;
    localparam int RANDOM_PIXELS = 200;

    // most samples the path can hold with the output stalled
    localparam int CAPACITY = IN_DEPTH + OUT_DEPTH + 1;

    // planned cycles of reset, corners, latency, back-pressure and random stream
    localparam int TEST_CYCLES     = 5 + 40 + 20 + 60 + RANDOM_PIXELS * 5;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 4;

    // corner pixels and their grey values worked out by hand
    localparam logic [RGB_BITS-1:0] CORNER_PX [5] = '{
        24'h000000, 24'hffffff, 24'h010100, 24'hff0000, 24'h030303
    };
    localparam logic [GRAY_BITS-1:0] CORNER_GRAY [5] = '{
        8'h00, 8'hff, 8'h00, 8'h55, 8'h03
    };

    logic                 clock;
    logic                 reset;
    logic                 in_wr_en;
    logic [RGB_BITS-1:0]  in_din;
    logic                 in_full;
    logic                 out_rd_en;
    logic [GRAY_BITS-1:0] out_dout;
    logic                 out_empty;

    // expected grey values in arrival order
    logic [GRAY_BITS-1:0] exp_q [$];
    // values actually popped in the current test
    logic [GRAY_BITS-1:0] seen [$];

    // registered copies for the assertions
    logic [GRAY_BITS-1:0] exp_head = '0;
    int in_flight = 0;

    int compared   = 0;
    int errors     = 0;
    int tests_done = 0;

    // producer still running in the random test
    logic producing;

    // write into a completely empty path
    logic idle_write;
    assign idle_write = in_wr_en && !in_full && (in_flight == 0);

    grayscale_top #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) grayscale_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // truncated mean of red, green and blue
    function automatic logic [GRAY_BITS-1:0] expected_gray(input logic [RGB_BITS-1:0] px);
        int total;
        total = int'(px[23:16]) + int'(px[15:8]) + int'(px[7:0]);
        return GRAY_BITS'(total / 3);
    endfunction

    task automatic fail_check(input string msg);
        errors++;
        $display("CHECK FAILED t=%0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
    endtask

    // entered just after a rising edge and returns just after the accepting edge
    task automatic push_pixel(input logic [RGB_BITS-1:0] px);
        in_wr_en <= 1'b1;
        in_din   <= px;
        @(negedge clock);
        while (in_full) begin
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            in_wr_en <= 1'b0;
            @(posedge clock);
        end
    endtask

    // reads with random stalls until nothing is left in flight
    task automatic consume(input int stall_pct);
        out_rd_en <= ($urandom_range(99) >= stall_pct);
        @(negedge clock);
        while (producing || in_flight != 0) begin
            @(posedge clock);
            out_rd_en <= ($urandom_range(99) >= stall_pct);
            @(negedge clock);
        end
        @(posedge clock);
        out_rd_en <= 1'b0;
    endtask

    // scoreboard model takes pops before pushes as the FIFOs do
    always @(posedge clock) begin
        if (!reset) begin
            if (out_rd_en && !out_empty) begin
                seen.push_back(out_dout);
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                compared++;
            end
            if (in_wr_en && !in_full) begin
                exp_q.push_back(expected_gray(in_din));
            end
            exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
            in_flight <= exp_q.size();
        end
    end

    // popped value must match the oldest expected one
    assert property (@(posedge clock) disable iff (reset)
        (out_rd_en && !out_empty) |-> (in_flight != 0 && out_dout == exp_head))
    else fail_check($sformatf("out_dout %02h, expected %02h",
                              $sampled(out_dout), $sampled(exp_head)));

    // input buffer cannot be full with fewer samples than its depth
    assert property (@(posedge clock) disable iff (reset)
        (in_flight < IN_DEPTH) |-> !in_full)
    else fail_check($sformatf("in_full high with %0d in flight", $sampled(in_flight)));

    // during reset and on the first edge after it
    assert property (@(posedge clock)
        (reset || $fell(reset)) |-> (out_empty && !in_full))
    else fail_check("flags wrong around reset");

    // output still empty two edges after a write into an idle path
    assert property (@(posedge clock) disable iff (reset)
        $past(idle_write, 2) |-> out_empty)
    else fail_check("out_empty fell early after idle write");

    // and not empty on the third edge
    assert property (@(posedge clock) disable iff (reset)
        $past(idle_write, 3) |-> !out_empty)
    else fail_check("out_empty still high three edges after idle write");

    initial begin : watchdog
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int accepted;
        int start_count;

        void'($urandom(32'ha885_27ed));
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        producing = 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // flags straight after reset
        @(posedge clock);
        @(negedge clock);
        assert (out_empty && !in_full)
        else fail_check("out_empty low or in_full high after reset");
        report_test("reset_state");
        @(posedge clock);

        // corner pixels back to back
        seen.delete();
        for (int i = 0; i < 5; i++) begin
            push_pixel(CORNER_PX[i]);
        end
        in_wr_en <= 1'b0;
        consume(0);
        assert (seen.size() == 5)
        else fail_check($sformatf("%0d corner outputs, expected 5", seen.size()));
        for (int i = 0; i < seen.size() && i < 5; i++) begin
            assert (seen[i] == CORNER_GRAY[i])
            else fail_check($sformatf("corner %0d gave %02h, expected %02h",
                                      i, seen[i], CORNER_GRAY[i]));
        end
        report_test("corner_pixels");

        // single pixel into an idle path for the latency assertions
        push_pixel(RGB_BITS'($urandom()));
        idle_cycles(5);
        consume(0);
        report_test("latency");

        // write every cycle with the output stalled until in_full rises
        accepted  = 0;
        in_wr_en <= 1'b1;
        in_din   <= RGB_BITS'($urandom());
        @(negedge clock);
        while (!in_full) begin
            @(posedge clock);
            accepted++;
            in_din <= RGB_BITS'($urandom());
            @(negedge clock);
        end
        @(posedge clock);
        in_wr_en <= 1'b0;
        assert (accepted == CAPACITY)
        else fail_check($sformatf("%0d pixels accepted, expected %0d", accepted, CAPACITY));
        consume(0);
        report_test("back_pressure");

        // random gaps on the write side and random stalls on the read side
        start_count = compared;
        producing   = 1'b1;
        fork
            begin
                for (int n = 0; n < RANDOM_PIXELS; n++) begin
                    idle_cycles($urandom_range(3));
                    push_pixel(RGB_BITS'($urandom()));
                end
                in_wr_en <= 1'b0;
                producing = 1'b0;
            end
            consume(35);
        join
        assert (compared - start_count == RANDOM_PIXELS)
        else fail_check($sformatf("%0d random outputs, expected %0d",
                                  compared - start_count, RANDOM_PIXELS));
        report_test("random_stream");

        $display("summary: %0d tests, %0d samples compared, %0d errors",
                 tests_done, compared, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- grayscale_top.sv
module grayscale_top #(
    parameter int IN_DEPTH  = stream_pkg::DEFAULT_IN_DEPTH,
    parameter int OUT_DEPTH = stream_pkg::DEFAULT_OUT_DEPTH
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_wr_en,
    input  logic [pixel_pkg::RGB_BITS-1:0] in_din,
    output logic                           in_full,
    input  logic                           out_rd_en,
    output logic [pixel_pkg::GRAY_BITS-1:0] out_dout,
    output logic                           out_empty
);

    import pixel_pkg::*;

    // rgb pixels from the producer to the converter
    fifo_if #(.WIDTH(RGB_BITS)) in_ch ();

    // grey bytes from the converter to the consumer
    fifo_if #(.WIDTH(GRAY_BITS)) out_ch ();

    // producer side of in_ch comes from the ports
    assign in_ch.wr_en = in_wr_en;
    assign in_ch.din   = in_din;
    assign in_full     = in_ch.full;

    // consumer side of out_ch comes from the ports
    assign out_ch.rd_en = out_rd_en;
    assign out_dout     = out_ch.dout;
    assign out_empty    = out_ch.empty;

    // input buffer
    sync_fifo #(
        .DEPTH (IN_DEPTH),
        .WIDTH (RGB_BITS)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .ch    (in_ch.storage)
    );

    // colour to grey, one pixel per two cycles at most
    grayscale gray_stage (
        .clock    (clock),
        .reset    (reset),
        .pixel_in (in_ch.reader),
        .gray_out (out_ch.writer)
    );

    // output buffer
    sync_fifo #(
        .DEPTH (OUT_DEPTH),
        .WIDTH (GRAY_BITS)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .ch    (out_ch.storage)
    );

endmodule

//--- pixel_pkg.sv
package pixel_pkg;

    // one colour channel, unsigned
    localparam int CHANNEL_BITS = 8;

    // packed pixel, red top byte, green middle, blue low
    localparam int RGB_BITS = 3 * CHANNEL_BITS;

    // grey sample width
    localparam int GRAY_BITS = 8;

    // two spare bits so three full channels cannot overflow
    localparam int SUM_BITS = CHANNEL_BITS + 2;

    // truncated mean of the three channels
    function automatic logic [GRAY_BITS-1:0] rgb_to_gray(
        input logic [CHANNEL_BITS-1:0] red,
        input logic [CHANNEL_BITS-1:0] green,
        input logic [CHANNEL_BITS-1:0] blue
    );
        logic [SUM_BITS-1:0] sum;
        sum = SUM_BITS'(red) + SUM_BITS'(green) + SUM_BITS'(blue);
        // max sum 765, so the quotient fits in 8 bits
        return GRAY_BITS'(sum / SUM_BITS'(3));
    endfunction

endpackage

//--- src.f
pixel_pkg.sv
stream_pkg.sv
fifo_if.sv
sync_fifo.sv
grayscale.sv
grayscale_top.sv
grayscale_tb.sv

//--- stream_pkg.sv
package stream_pkg;

    // input buffer default, absorbs producer bursts
    localparam int DEFAULT_IN_DEPTH = 16;

    // output buffer default
    localparam int DEFAULT_OUT_DEPTH = 8;

    // address bits needed to index a depth
    // depth is a power of two, 2 or more
    function automatic int ptr_bits(input int depth);
        int bits;
        bits = 0;
        while ((1 << bits) < depth) begin
            bits = bits + 1;
        end
        return bits;
    endfunction

endpackage

//--- sync_fifo.sv
module sync_fifo #(
    parameter int DEPTH = 2,
    parameter int WIDTH = 8
) (
    input logic     clock,
    input logic     reset,
    fifo_if.storage ch
);

    import stream_pkg::*;

    // pointers carry one extra wrap bit above the address
    localparam int PTR_BITS = ptr_bits(DEPTH);

    // storage array
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;

    // entries currently held
    logic [PTR_BITS:0] count;

    // accepted push and pop this cycle
    logic do_write;
    logic do_read;

    // writes while full and reads while empty are dropped
    assign do_write = ch.wr_en && !ch.full;
    assign do_read  = ch.rd_en && !ch.empty;

    // both pointers on the same address and lap
    assign ch.empty = (wr_ptr == rd_ptr);

    // same address with the writer one lap ahead
    assign ch.full = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS])
                  && (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    // wraps cleanly thanks to the extra pointer bit
    assign count = wr_ptr - rd_ptr;

    // oldest word always on dout
    assign ch.dout = mem[rd_ptr[PTR_BITS-1:0]];

    // data path
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= ch.din;
        end
    end

    // write pointer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // the two flags never clash
    assert property (@(posedge clock) disable iff (reset)
        !(ch.full && ch.empty))
    else $error("sync_fifo: full and empty both high");

    // occupancy never above the depth
    assert property (@(posedge clock) disable iff (reset)
        count <= DEPTH)
    else $error("sync_fifo: occupancy %0d above depth %0d", count, DEPTH);

endmodule
